/* Makefile */
# Verilator build and run, relaxed and strict ordering
VERILATOR ?= verilator

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench in relaxed and strict mode"
	@echo "  clean  remove build directories and logs"

test:
	$(VERILATOR) --binary --timing --assert -Wno-fatal -f vlog.f \
	  --top-module tb_request_aligner -GRELAX_MODE=1 --Mdir obj_relax -o sim
	./obj_relax/sim | tee relax.log
	grep -q "PASS: all tests" relax.log
	$(VERILATOR) --binary --timing --assert -Wno-fatal -f vlog.f \
	  --top-module tb_request_aligner -GRELAX_MODE=0 --Mdir obj_strict -o sim
	./obj_strict/sim | tee strict.log
	grep -q "PASS: all tests" strict.log

clean:
	rm -rf obj_relax obj_strict relax.log strict.log

/* rtl/corebus_cmd_data_aligner.sv */
//====================
// command/data aligner with request fifos
// and held request info
//====================
`timescale 1ns/1ps
`default_nettype none

module corebus_cmd_data_aligner #(
  parameter int FIFO_DEPTH    = 2,
  parameter bit RELAX_MODE    = 1,
  parameter bit WAIT_FOR_DATA = 0
)(
  input  var logic                       i_clk,
  input  var logic                       i_rst_n,
  input  var logic                       i_cmd_valid,
  input  var corebus_pkg::corebus_cmd_t  i_cmd,
  output logic                           o_cmd_accept,
  input  var logic                       i_data_valid,
  input  var corebus_pkg::corebus_data_t i_data,
  output logic                           o_data_accept,
  output logic                           o_cmd_valid,
  output corebus_pkg::corebus_cmd_t      o_cmd,
  input  var logic                       i_cmd_accept,
  output logic                           o_data_valid,
  output corebus_pkg::corebus_data_t     o_data,
  input  var logic                       i_data_accept,
  output corebus_pkg::corebus_info_t     o_info,
  output logic                           o_cmd_done,
  output logic                           o_data_done
);
  import corebus_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ACTIVE,
    DONE
  } state_e;

  logic          f_cmd_valid;
  corebus_cmd_t  f_cmd;
  logic          f_cmd_accept;
  logic          f_data_valid;
  corebus_data_t f_data;
  logic          f_data_accept;

  state_e        cmd_state;
  state_e        data_state;
  logic          write_cmd_valid;
  logic          write_cmd_ack;
  logic          last_ack;
  logic          cmd_done;
  logic          data_done;
  logic          cmd_ready;
  logic          data_ready;
  corebus_info_t info_q;

  corebus_fifo #(
    .DEPTH  (FIFO_DEPTH),
    .ITEM_T (corebus_cmd_t)
  ) u_cmd_fifo (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_in_valid   (i_cmd_valid),
    .i_in_item    (i_cmd),
    .o_in_accept  (o_cmd_accept),
    .o_out_valid  (f_cmd_valid),
    .o_out_item   (f_cmd),
    .i_out_accept (f_cmd_accept)
  );

  corebus_fifo #(
    .DEPTH  (FIFO_DEPTH),
    .ITEM_T (corebus_data_t)
  ) u_data_fifo (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_in_valid   (i_data_valid),
    .i_in_item    (i_data),
    .o_in_accept  (o_data_accept),
    .o_out_valid  (f_data_valid),
    .o_out_item   (f_data),
    .i_out_accept (f_data_accept)
  );

  // handshake events seen at the master port
  assign write_cmd_valid = f_cmd_valid && cmd_has_data(f_cmd.cmd);
  assign write_cmd_ack   = write_cmd_valid && cmd_ready && i_cmd_accept;
  assign last_ack        = f_data_valid && data_ready && i_data_accept && f_data.last;
  assign cmd_done        = (cmd_state == DONE) || write_cmd_ack;
  assign data_done       = (data_state == DONE) || last_ack;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      cmd_state <= IDLE;
    end else begin
      case (cmd_state)
        IDLE:    if (cmd_done && !data_done) cmd_state <= DONE;  // write out, burst open
        DONE:    if (data_done) cmd_state <= IDLE;
        default: cmd_state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      data_state <= IDLE;
    end else begin
      case (data_state)
        IDLE: begin
          if (cmd_done) begin
            if (!data_done) data_state <= ACTIVE;
          end else if (RELAX_MODE && write_cmd_valid) begin
            // command presented but not yet taken
            if (data_done) begin
              data_state <= DONE;
            end else if (!WAIT_FOR_DATA || f_data_valid) begin
              data_state <= ACTIVE;
            end
          end
        end
        ACTIVE: begin
          if (data_done) data_state <= (!RELAX_MODE || cmd_done) ? IDLE : DONE;
        end
        DONE:    if (cmd_done) data_state <= IDLE;
        default: data_state <= IDLE;
      endcase
    end
  end

  // accept gating toward the master port
  always_comb begin
    if (cmd_state == IDLE) begin
      cmd_ready = !WAIT_FOR_DATA || !cmd_has_data(f_cmd.cmd) || f_data_valid ||
                  (data_state != IDLE);
    end else begin
      cmd_ready = 1'b0;  // hold commands until the burst completes
    end
    case (data_state)
      IDLE:    data_ready = RELAX_MODE && write_cmd_valid;  // strict waits for ACTIVE
      ACTIVE:  data_ready = 1'b1;
      default: data_ready = 1'b0;
    endcase
  end

  assign o_cmd_valid   = cmd_ready && f_cmd_valid;
  assign f_cmd_accept  = cmd_ready && i_cmd_accept;
  assign o_cmd         = f_cmd;
  assign o_data_valid  = data_ready && f_data_valid;
  assign f_data_accept = data_ready && i_data_accept;
  assign o_data        = f_data;

  // held copy of the write in progress
  always_ff @(posedge i_clk) begin
    if (write_cmd_ack) info_q <= f_cmd;
  end

  assign o_info      = (cmd_state == IDLE) ? f_cmd : info_q;
  assign o_cmd_done  = cmd_state == DONE;
  assign o_data_done = data_state == DONE;

endmodule

`default_nettype wire

/* rtl/corebus_fifo.sv */
//====================
// synchronous fifo for a packed payload
//====================
`timescale 1ns/1ps
`default_nettype none

module corebus_fifo #(
  parameter int  DEPTH  = 2,
  parameter type ITEM_T = logic
)(
  input  var logic  i_clk,
  input  var logic  i_rst_n,
  input  var logic  i_in_valid,
  input  var ITEM_T i_in_item,
  output logic      o_in_accept,
  output logic      o_out_valid,
  output ITEM_T     o_out_item,
  input  var logic  i_out_accept
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  ITEM_T            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;  // wrap at DEPTH
  endfunction

  assign o_in_accept = count < FULL_CNT;
  assign o_out_valid = count != '0;
  assign o_out_item  = mem[rd_ptr];

  assign push = i_in_valid && o_in_accept;
  assign pop  = o_out_valid && i_out_accept;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  // storage
  always_ff @(posedge i_clk) begin
    if (push) mem[wr_ptr] <= i_in_item;
  end

endmodule

`default_nettype wire

/* rtl/corebus_pkg.sv */
//====================
// corebus request types, widths and command helpers
//====================
`default_nettype none

package corebus_pkg;

  // bus widths
  localparam int ADDR_WIDTH = 16;
  localparam int DATA_WIDTH = 32;
  localparam int ID_WIDTH   = 4;
  localparam int LEN_WIDTH  = 3;  // 0 means one beat, 7 means eight
  localparam int BE_WIDTH   = DATA_WIDTH / 8;

  // command kinds, only writes carry data
  typedef enum logic [1:0] {
    CMD_READ    = 2'd0,
    CMD_WRITE   = 2'd1,
    CMD_MESSAGE = 2'd2
  } corebus_cmd_e;

  typedef struct packed {
    corebus_cmd_e          cmd;
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]  len;
  } corebus_cmd_t;  // 25 bits

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [BE_WIDTH-1:0]   byte_en;
    logic                  last;   // final beat of the burst
  } corebus_data_t;  // 37 bits

  // request info on the status port, same layout as a command
  typedef corebus_cmd_t corebus_info_t;

  function automatic logic cmd_has_data(input corebus_cmd_e cmd);
    return cmd == CMD_WRITE;
  endfunction

endpackage

`default_nettype wire

/* rtl/corebus_request_aligner_top.sv */
//====================
// request aligner top level
//====================
`timescale 1ns/1ps
`default_nettype none

module corebus_request_aligner_top #(
  parameter int FIFO_DEPTH    = 2,
  parameter bit RELAX_MODE    = 1,
  parameter bit WAIT_FOR_DATA = 0
)(
  input  var logic                       i_clk,
  input  var logic                       i_rst_n,
  // slave port
  input  var logic                       i_cmd_valid,
  input  var corebus_pkg::corebus_cmd_t  i_cmd,
  output logic                           o_cmd_accept,
  input  var logic                       i_data_valid,
  input  var corebus_pkg::corebus_data_t i_data,
  output logic                           o_data_accept,
  // master port
  output logic                           o_cmd_valid,
  output corebus_pkg::corebus_cmd_t      o_cmd,
  input  var logic                       i_cmd_accept,
  output logic                           o_data_valid,
  output corebus_pkg::corebus_data_t     o_data,
  input  var logic                       i_data_accept,
  // status
  output corebus_pkg::corebus_info_t     o_info,
  output logic                           o_cmd_done,
  output logic                           o_data_done
);

  corebus_cmd_data_aligner #(
    .FIFO_DEPTH    (FIFO_DEPTH),
    .RELAX_MODE    (RELAX_MODE),
    .WAIT_FOR_DATA (WAIT_FOR_DATA)
  ) u_aligner (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_cmd_valid   (i_cmd_valid),
    .i_cmd         (i_cmd),
    .o_cmd_accept  (o_cmd_accept),
    .i_data_valid  (i_data_valid),
    .i_data        (i_data),
    .o_data_accept (o_data_accept),
    .o_cmd_valid   (o_cmd_valid),
    .o_cmd         (o_cmd),
    .i_cmd_accept  (i_cmd_accept),
    .o_data_valid  (o_data_valid),
    .o_data        (o_data),
    .i_data_accept (i_data_accept),
    .o_info        (o_info),
    .o_cmd_done    (o_cmd_done),
    .o_data_done   (o_data_done)
  );

endmodule

`default_nettype wire

/* test/request_aligner_props.sv */
//====================
// ordering assertions for the aligner, bound in
//====================
`timescale 1ns/1ps
`default_nettype none

module request_aligner_props #(
  parameter bit RELAX_MODE = 1
)(
  input var logic                      i_clk,
  input var logic                      i_rst_n,
  input var logic                      i_cmd_valid,
  input var corebus_pkg::corebus_cmd_t i_cmd,
  input var logic                      i_cmd_accept,
  input var logic                      i_data_valid,
  input var logic                      i_data_last,
  input var logic                      i_data_accept,
  input var logic                      i_cmd_done,
  input var logic                      i_data_done
);
  import corebus_pkg::*;

  int   writes;  // write commands sent
  int   bursts;  // last beats sent
  logic cmd_fire;
  logic data_fire;
  logic write_shown;

  assign cmd_fire    = i_cmd_valid && i_cmd_accept;
  assign data_fire   = i_data_valid && i_data_accept;
  assign write_shown = i_cmd_valid && (i_cmd.cmd == CMD_WRITE);

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      writes <= 0;
      bursts <= 0;
    end else begin
      if (cmd_fire && write_shown) writes <= writes + 1;
      if (data_fire && i_data_last) bursts <= bursts + 1;
    end
  end

  // no command leaves while a burst is open
  a_cmd_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (writes > bursts) |-> !i_cmd_valid)
    else $error("command presented while a write burst is open");

  a_data_order: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    data_fire |-> ((writes > bursts) || (RELAX_MODE && write_shown && writes == bursts)))
    else $error("data beat sent ahead of its write command");

  a_flags: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_cmd_done && i_data_done))
    else $error("command and data done flags high together");

endmodule

bind corebus_cmd_data_aligner request_aligner_props #(
  .RELAX_MODE (RELAX_MODE)
) u_props (
  .i_clk         (i_clk),
  .i_rst_n       (i_rst_n),
  .i_cmd_valid   (o_cmd_valid),
  .i_cmd         (o_cmd),
  .i_cmd_accept  (i_cmd_accept),
  .i_data_valid  (o_data_valid),
  .i_data_last   (o_data.last),
  .i_data_accept (i_data_accept),
  .i_cmd_done    (o_cmd_done),
  .i_data_done   (o_data_done)
);

`default_nettype wire

/* test/tb_request_aligner.sv */
//====================
// request aligner testbench: random streams,
// reference model, checks and report
//====================
`timescale 1ns/1ps
`default_nettype none

module tb_request_aligner #(
  parameter bit RELAX_MODE = 1
);
  import corebus_pkg::*;

  localparam int FIFO_DEPTH = 2;
  localparam int N_TESTS    = 4;

  logic          i_clk;
  logic          i_rst_n;
  logic          i_cmd_valid;
  corebus_cmd_t  i_cmd;
  logic          o_cmd_accept;
  logic          i_data_valid;
  corebus_data_t i_data;
  logic          o_data_accept;
  logic          o_cmd_valid;
  corebus_cmd_t  o_cmd;
  logic          i_cmd_accept;
  logic          o_data_valid;
  corebus_data_t o_data;
  logic          i_data_accept;
  corebus_info_t o_info;
  logic          o_cmd_done;
  logic          o_data_done;

  corebus_cmd_t  cmd_q[$];   // slave command stream, all tests
  corebus_data_t data_q[$];  // slave data stream
  int            cmd_end[N_TESTS];
  int            data_end[N_TESTS];
  int            test_idx;
  int            cmd_in;     // items taken at the slave port
  int            data_in;
  int            cmd_out;    // items seen at the master port
  int            data_out;
  int            writes_out;
  int            bursts_out;
  corebus_cmd_t  held_write;
  bit            cmd_in_fire;
  bit            data_in_fire;
  bit            stall_mode;
  int            stall_left;
  int            errors;
  int            checks;
  int            err_start;
  int            cycles;
  int            limit = 0;

  corebus_request_aligner_top #(
    .FIFO_DEPTH    (FIFO_DEPTH),
    .RELAX_MODE    (RELAX_MODE),
    .WAIT_FOR_DATA (1'b0)
  ) DUT (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_cmd_valid   (i_cmd_valid),
    .i_cmd         (i_cmd),
    .o_cmd_accept  (o_cmd_accept),
    .i_data_valid  (i_data_valid),
    .i_data        (i_data),
    .o_data_accept (o_data_accept),
    .o_cmd_valid   (o_cmd_valid),
    .o_cmd         (o_cmd),
    .i_cmd_accept  (i_cmd_accept),
    .o_data_valid  (o_data_valid),
    .o_data        (o_data),
    .i_data_accept (i_data_accept),
    .o_info        (o_info),
    .o_cmd_done    (o_cmd_done),
    .o_data_done   (o_data_done)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_violation(input string what);
    errors++;
    $display("Error at %0t ns: %s", $time, what);
  endtask

  // held write while its burst is open, otherwise the next command in order
  function automatic corebus_info_t expected_info(input int w_out, input int b_out,
                                                  input corebus_cmd_t held,
                                                  input corebus_cmd_t head);
    if (w_out > b_out) return held;
    return head;
  endfunction

  function automatic string test_name(input int idx);
    case (idx)
      0:       return "reset";
      1:       return "mixed traffic";
      2:       return "back-pressure";
      default: return "write bursts";
    endcase
  endfunction

  task automatic add_commands(input int n, input bit writes_only);
    corebus_cmd_t  c;
    corebus_data_t d;
    for (int i = 0; i < n; i++) begin
      c.cmd  = writes_only ? CMD_WRITE : corebus_cmd_e'($urandom_range(2, 0));
      c.id   = 4'($urandom);
      c.addr = 16'($urandom);
      c.len  = 3'($urandom);
      cmd_q.push_back(c);
      if (c.cmd == CMD_WRITE) begin
        for (int b = 0; b <= int'(c.len); b++) begin
          d.data    = $urandom;
          d.byte_en = 4'($urandom);
          d.last    = (b == int'(c.len));  // len+1 beats
          data_q.push_back(d);
        end
      end
    end
  endtask

  task automatic drive_inputs();
    if (cmd_in_fire) cmd_in++;
    if (!i_cmd_valid || cmd_in_fire) begin  // hold until taken
      if (cmd_in < cmd_end[test_idx] && $urandom_range(2, 0) != 0) begin
        i_cmd_valid = 1'b1;
        i_cmd       = cmd_q[cmd_in];
      end else begin
        i_cmd_valid = 1'b0;
      end
    end
    if (data_in_fire) data_in++;
    if (!i_data_valid || data_in_fire) begin
      if (data_in < data_end[test_idx] && $urandom_range(2, 0) != 0) begin
        i_data_valid = 1'b1;
        i_data       = data_q[data_in];
      end else begin
        i_data_valid = 1'b0;
      end
    end
    if (stall_left > 0) begin
      stall_left--;
      i_cmd_accept  = 1'b0;
      i_data_accept = 1'b0;
    end else begin
      if (stall_mode && $urandom_range(11, 0) == 0) stall_left = $urandom_range(24, 8);
      i_cmd_accept  = $urandom_range(3, 0) != 0;
      i_data_accept = $urandom_range(3, 0) != 0;
    end
  endtask

  task automatic observe();
    bit           cmd_fire;
    bit           data_fire;
    bit           head_write;
    int           w0;
    int           b0;
    corebus_cmd_t head;
    cmd_fire   = o_cmd_valid && i_cmd_accept;
    data_fire  = o_data_valid && i_data_accept;
    w0         = writes_out;
    b0         = bursts_out;
    head       = '0;
    if (cmd_out < cmd_q.size()) head = cmd_q[cmd_out];
    head_write = head.cmd == CMD_WRITE;
    cmd_in_fire  = i_cmd_valid && o_cmd_accept;
    data_in_fire = i_data_valid && o_data_accept;
    if (!i_rst_n) begin
      check("o_cmd_valid", 64'(o_cmd_valid), 64'(0));
      check("o_data_valid", 64'(o_data_valid), 64'(0));
      check("o_cmd_done", 64'(o_cmd_done), 64'(0));
      check("o_data_done", 64'(o_data_done), 64'(0));
      return;
    end
    // fifo occupancy decides the slave accepts
    check("o_cmd_accept", 64'(o_cmd_accept), 64'(cmd_in - cmd_out < FIFO_DEPTH));
    check("o_data_accept", 64'(o_data_accept), 64'(data_in - data_out < FIFO_DEPTH));
    if (o_cmd_valid && cmd_in == cmd_out)
      report_violation("command valid at the master port before any was accepted");
    if (o_data_valid && data_in == data_out)
      report_violation("data valid at the master port before any beat was accepted");
    check("o_cmd_done", 64'(o_cmd_done), 64'(w0 > b0));
    check("o_data_done", 64'(o_data_done), 64'(b0 > w0));
    if (w0 > b0 || o_cmd_valid)
      check("o_info", 64'(o_info), 64'(expected_info(w0, b0, held_write, head)));
    if (cmd_fire) begin
      if (cmd_out >= cmd_q.size()) begin
        report_violation("extra command at the master port");
      end else begin
        check("o_cmd", 64'(o_cmd), 64'(head));
        if (w0 > b0) report_violation("command accepted while a write burst was open");
        if (head_write) begin
          held_write = head;
          writes_out++;
        end
        cmd_out++;
      end
    end
    if (data_fire) begin
      if (data_out >= data_q.size()) begin
        report_violation("extra data beat at the master port");
      end else begin
        check("o_data", 64'(o_data), 64'(data_q[data_out]));
        if (!(w0 > b0 || (RELAX_MODE && o_cmd_valid && head_write && w0 == b0)))
          report_violation("data beat accepted before its write command");
        if (data_q[data_out].last) bursts_out++;
        data_out++;
      end
    end
  endtask

  // compare mid-cycle, after the falling-edge drive has settled
  always @(negedge i_clk) begin
    #2;
    observe();
  end

  initial begin
    cycles = 0;
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge i_clk);
      cycles++;
    end
    $display("Error: timeout after %0d cycles, the streams did not drain", cycles);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    void'($urandom(80278));
    i_rst_n       = 1'b0;
    i_cmd_valid   = 1'b0;
    i_cmd         = '0;
    i_data_valid  = 1'b0;
    i_data        = '0;
    i_cmd_accept  = 1'b0;
    i_data_accept = 1'b0;
    test_idx      = 0;
    stall_mode    = 1'b0;
    stall_left    = 0;
    errors        = 0;
    checks        = 0;
    cmd_end[0]    = 0;
    data_end[0]   = 0;
    add_commands(40, 1'b0);
    cmd_end[1]  = cmd_q.size();
    data_end[1] = data_q.size();
    add_commands(40, 1'b0);
    cmd_end[2]  = cmd_q.size();
    data_end[2] = data_q.size();
    add_commands(30, 1'b1);
    cmd_end[3]  = cmd_q.size();
    data_end[3] = data_q.size();
    limit = 20 * (cmd_q.size() + data_q.size()) + 200;

    repeat (16) @(negedge i_clk);
    i_rst_n = 1'b1;
    repeat (2) @(negedge i_clk);
    $display("test 0 (%s) finished: %0d errors", test_name(0), errors);

    for (test_idx = 1; test_idx < N_TESTS; test_idx++) begin
      err_start  = errors;
      stall_mode = (test_idx == 2);  // long stretches of low master accepts
      while (cmd_out < cmd_end[test_idx] || data_out < data_end[test_idx]) begin
        @(negedge i_clk);
        drive_inputs();
      end
      $display("test %0d (%s) finished: %0d errors", test_idx, test_name(test_idx),
               errors - err_start);
    end

    $display("tests: %0d, checks: %0d, errors: %0d", N_TESTS, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
rtl/corebus_pkg.sv
rtl/corebus_fifo.sv
rtl/corebus_cmd_data_aligner.sv
rtl/corebus_request_aligner_top.sv
test/request_aligner_props.sv
test/tb_request_aligner.sv
